//--- flist.f
design/tm_pio_pkg.sv
design/tm_mem_if.sv
design/tm_cfg_mem.sv
design/tm_pio.sv
design/tm_cfg_top.sv
bench/tb_clk_gen.sv
bench/tb_tm_checker.sv
bench/tb_tm_cfg_asserts.sv
bench/tb_tm_cfg.sv

//--- Makefile
TOOL      = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = tb_tm_cfg
FLIST     = flist.f
BUILD_DIR = obj_dir
LOG       = sim.log
FAIL_MSG  = Finished with errors
PASS_MSG  = Finished with no errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "TEST FAILED"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "TEST FAILED: run ended early"; exit 1; fi
	@echo "TEST PASSED"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/tb_tm_cfg.sv
// ##############################
// Testbench of the TM config block, driven from a table of accesses.
// clk_div is random but high at least once in any four cycles.
// Expected read data is the written word masked to the table payload.
// ##############################

`timescale 1ns/1ps

module tb_tm_cfg;

	import tm_pio_pkg::*;

	localparam int ACK_TIMEOUT = 50;
	localparam int NUM_ROWS = 34;

	typedef struct packed {
		logic rd;          // 1 reads, 0 writes.
		pio_word_t addr;
		pio_word_t wdata;
		pio_word_t exp;    // Expected data of a read.
	} row_t;

	localparam row_t STIM [NUM_ROWS] = '{
		'{1'b1, 32'h0000_0007, 32'h0000_0000, 32'h0000_0000},
		'{1'b1, 32'h0000_001F, 32'h0000_0000, 32'h0000_0000},
		'{1'b1, 32'h0000_002A, 32'h0000_0000, 32'h0000_0000},
		'{1'b1, 32'h0000_0033, 32'h0000_0000, 32'h0000_0000},
		'{1'b0, 32'h0000_0000, 32'hA5A5_5A3C, 32'h0000_0000},
		'{1'b0, 32'h0000_000F, 32'h1234_56C7, 32'h0000_0000},
		'{1'b0, 32'h0000_0010, 32'hDEAD_BEEF, 32'h0000_0000},
		'{1'b0, 32'h0000_001F, 32'h0F0F_F0F0, 32'h0000_0000},
		'{1'b0, 32'h0000_0020, 32'hCAFE_1357, 32'h0000_0000},
		'{1'b0, 32'h0000_002F, 32'h8765_4321, 32'h0000_0000},
		'{1'b0, 32'h0000_0030, 32'h89AB_CDEF, 32'h0000_0000},
		'{1'b0, 32'h0000_003F, 32'h0000_0001, 32'h0000_0000},
		'{1'b0, 32'h0000_0035, 32'hFFFF_FFFF, 32'h0000_0000},
		'{1'b1, 32'h0000_0000, 32'h0000_0000, 32'h0000_003C},
		'{1'b1, 32'h0000_000F, 32'h0000_0000, 32'h0000_00C7},
		'{1'b1, 32'h0000_0010, 32'h0000_0000, 32'h00AD_BEEF},
		'{1'b1, 32'h0000_001F, 32'h0000_0000, 32'h000F_F0F0},
		'{1'b1, 32'h0000_0020, 32'h0000_0000, 32'h0000_1357},
		'{1'b1, 32'h0000_002F, 32'h0000_0000, 32'h0000_4321},
		'{1'b1, 32'h0000_0030, 32'h0000_0000, 32'h89AB_CDEF},
		'{1'b1, 32'h0000_003F, 32'h0000_0000, 32'h0000_0001},
		'{1'b1, 32'h0000_0035, 32'h0000_0000, 32'hFFFF_FFFF},
		'{1'b1, 32'h0000_0045, 32'h0000_0000, 32'h0000_0000},
		'{1'b1, 32'h0000_00F0, 32'h0000_0000, 32'h0000_0000},
		'{1'b0, 32'h0000_0040, 32'h1111_1111, 32'h0000_0000},
		'{1'b0, 32'h0000_00AB, 32'h5555_5555, 32'h0000_0000},
		'{1'b1, 32'h0000_0000, 32'h0000_0000, 32'h0000_003C},
		'{1'b1, 32'h0000_0020, 32'h0000_0000, 32'h0000_1357},
		'{1'b1, 32'h0000_000B, 32'h0000_0000, 32'h0000_0000},
		'{1'b1, 32'h0000_003B, 32'h0000_0000, 32'h0000_0000},
		'{1'b0, 32'h0000_0000, 32'h0000_0077, 32'h0000_0000},
		'{1'b1, 32'h0000_0000, 32'h0000_0000, 32'h0000_0077},
		'{1'b0, 32'h0000_002F, 32'hFFFF_00AA, 32'h0000_0000},
		'{1'b1, 32'h0000_002F, 32'h0000_0000, 32'h0000_00AA}
	};

	logic clk;
	logic rst_n;
	logic clk_div = 1'b0;
	logic reg_bs;
	logic reg_wr;
	logic reg_rd;
	pio_word_t reg_addr;
	pio_word_t reg_din;
	logic pio_ack;
	logic pio_rvalid;
	pio_word_t pio_rdata;
	logic exp_rd;
	pio_word_t exp_data;
	int err_count;
	int check_count;
	int timeout_count;
	int seed = 12819;
	int rnd;
	int gap;

	tb_clk_gen clk_gen_i (
		.clk(clk),
		.rst_n(rst_n)
	);

	tm_cfg_top tm_cfg_top_i (
		.clk(clk),
		.rst_n(rst_n),
		.clk_div(clk_div),
		.reg_bs(reg_bs),
		.reg_wr(reg_wr),
		.reg_rd(reg_rd),
		.reg_addr(reg_addr),
		.reg_din(reg_din),
		.pio_ack(pio_ack),
		.pio_rvalid(pio_rvalid),
		.pio_rdata(pio_rdata)
	);

	tb_tm_checker checker_i (
		.clk(clk),
		.rst_n(rst_n),
		.pio_ack(pio_ack),
		.pio_rvalid(pio_rvalid),
		.pio_rdata(pio_rdata),
		.reg_addr(reg_addr),
		.exp_rd(exp_rd),
		.exp_data(exp_data),
		.err_count(err_count),
		.check_count(check_count)
	);

	// gap counts low cycles in a row and forces the fourth one high.
	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			clk_div <= 1'b0;
			gap <= 0;
		end else if (gap == 3) begin
			clk_div <= 1'b1;
			gap <= 0;
		end else begin
			rnd = $random(seed);
			clk_div <= rnd[0];
			gap <= rnd[0] ? 0 : gap + 1;
		end
	end

	task automatic wait_for_ack(input logic level);
		int cycles;
		cycles = 0;
		@(negedge clk);
		while ((pio_ack !== level) && (cycles < ACK_TIMEOUT)) begin
			@(negedge clk);
			cycles++;
		end
		if (pio_ack !== level) begin
			$display("Timeout at %0t: pio_ack did not go to %0b within %0d cycles",
				$time, level, ACK_TIMEOUT);
			timeout_count++;
		end
	endtask

	task automatic run_access(input row_t row);
		@(posedge clk);
		reg_bs <= 1'b1;
		reg_wr <= ~row.rd;
		reg_rd <= row.rd;
		reg_addr <= row.addr;
		reg_din <= row.wdata;
		exp_rd <= row.rd;
		exp_data <= row.exp;
		wait_for_ack(1'b1);
		@(posedge clk);
		reg_bs <= 1'b0;
		reg_wr <= 1'b0;
		reg_rd <= 1'b0;
		wait_for_ack(1'b0);  // The next access starts only after pio_ack is low.
	endtask

	initial begin
		int reset_cycles;
		int assert_fails;
		reg_bs = 1'b0;
		reg_wr = 1'b0;
		reg_rd = 1'b0;
		reg_addr = '0;
		reg_din = '0;
		exp_rd = 1'b0;
		exp_data = '0;
		timeout_count = 0;
		reset_cycles = 0;
		@(negedge clk);
		while (!rst_n && (reset_cycles < 10)) begin
			@(negedge clk);
			reset_cycles++;
		end
		if (!rst_n) begin
			$display("Timeout at %0t: reset was never released", $time);
			timeout_count++;
		end
		for (int i = 0; i < NUM_ROWS; i++) begin
			run_access(STIM[i]);
		end
		assert_fails = tm_cfg_top_i.tm_pio_i.tm_pio_asserts_i.fail_count;
		$display("Result: %0d checked, %0d mismatches, %0d timeouts, %0d assertion failures",
			check_count, err_count, timeout_count, assert_fails);
		if ((err_count == 0) && (timeout_count == 0) && (assert_fails == 0)) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

//--- bench/tb_tm_cfg_asserts.sv
// ##############################
// Handshake properties of tm_pio, bound into every instance of it.
// sel and ack bits are ordered qa, qp, wq, sp from bit 0 up.
// ##############################

`timescale 1ns/1ps

module tb_tm_cfg_asserts (
	input logic clk,
	input logic rst_n,
	input logic clk_div,
	input logic reg_bs,
	input logic pio_ack,
	input logic pio_rvalid,
	input logic [3:0] sel,
	input logic [3:0] ack
);

	int fail_count = 0;

	rvalid_with_ack: assert property (@(posedge clk) disable iff (!rst_n)
		pio_rvalid |-> pio_ack)
		else begin
			fail_count++;
			$error("pio_rvalid is high while pio_ack is low");
		end

	single_sel: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0(sel))
		else begin
			fail_count++;
			$error("more than one table select is high");
		end

	// A rising ack bit must have had its sel high on the cycle before.
	ack_after_sel: assert property (@(posedge clk) disable iff (!rst_n)
		(ack & ~$past(ack) & ~$past(sel)) == 4'b0000)
		else begin
			fail_count++;
			$error("table ack rose without sel on the previous cycle");
		end

	ack_release: assert property (@(posedge clk) disable iff (!rst_n)
		(pio_ack && !reg_bs && clk_div) |=> !pio_ack)
		else begin
			fail_count++;
			$error("pio_ack stayed high after reg_bs dropped and clk_div came");
		end

endmodule

bind tm_pio tb_tm_cfg_asserts tm_pio_asserts_i (
	.clk(clk),
	.rst_n(rst_n),
	.clk_div(clk_div),
	.reg_bs(reg_bs),
	.pio_ack(pio_ack),
	.pio_rvalid(pio_rvalid),
	.sel({sp_if.sel, wq_if.sel, qp_if.sel, qa_if.sel}),
	.ack({sp_if.ack, wq_if.ack, qp_if.ack, qa_if.ack})
);

//--- bench/tb_tm_checker.sv
// ##############################
// Watches the PIO ports and checks each access when pio_ack rises.
// Expected values come from the driver, sampled on the falling edge.
// ##############################

`timescale 1ns/1ps

module tb_tm_checker (
	input logic clk,
	input logic rst_n,
	input logic pio_ack,
	input logic pio_rvalid,
	input tm_pio_pkg::pio_word_t pio_rdata,
	input tm_pio_pkg::pio_word_t reg_addr,
	input logic exp_rd,
	input tm_pio_pkg::pio_word_t exp_data,
	output int err_count,
	output int check_count
);

	import tm_pio_pkg::*;

	logic ack_q;

	always @(negedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ack_q <= 1'b0;
			err_count <= 0;
			check_count <= 0;
		end else begin
			ack_q <= pio_ack;
			if (pio_ack && !ack_q) begin
				check_count <= check_count + 1;
				if (pio_rvalid !== exp_rd) begin
					$display("MISMATCH at %0t: addr 0x%08h pio_rvalid %0b, expected %0b",
						$time, reg_addr, pio_rvalid, exp_rd);
					err_count <= err_count + 1;
				end else if (exp_rd && (pio_rdata !== exp_data)) begin
					$display("MISMATCH at %0t: addr 0x%08h read 0x%08h, expected 0x%08h",
						$time, reg_addr, pio_rdata, exp_data);
					err_count <= err_count + 1;
				end
			end
		end
	end

endmodule

//--- bench/tb_clk_gen.sv
// ##############################
// Clock of 100 ns and an active low reset held for two rising edges.
// ##############################

`timescale 1ns/1ps

module tb_clk_gen (
	output logic clk,
	output logic rst_n
);

	localparam int HALF_PERIOD = 50;

	initial begin
		clk = 1'b0;
		forever #(HALF_PERIOD) clk = ~clk;
	end

	initial begin
		rst_n = 1'b0;
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;  // Released after two full cycles.
	end

endmodule

//--- design/tm_cfg_top.sv
// ##############################
// TM config block: PIO decoder plus four config tables.
// Tables are queue association, queue profile, WDRR quantum and CIR shaping.
// Address bits 7:4 pick the table, bits 3:0 the entry.
// ##############################

`timescale 1ns/1ps

module tm_cfg_top (
	input logic clk,
	input logic rst_n,
	input logic clk_div,

	input logic reg_bs,
	input logic reg_wr,
	input logic reg_rd,
	input tm_pio_pkg::pio_word_t reg_addr,
	input tm_pio_pkg::pio_word_t reg_din,

	output logic pio_ack,
	output logic pio_rvalid,
	output tm_pio_pkg::pio_word_t pio_rdata
);

	import tm_pio_pkg::*;

	tm_mem_if qa_if ();
	tm_mem_if qp_if ();
	tm_mem_if wq_if ();
	tm_mem_if sp_if ();

	tm_pio tm_pio_i (
		.clk(clk),
		.rst_n(rst_n),
		.clk_div(clk_div),
		.reg_bs(reg_bs),
		.reg_wr(reg_wr),
		.reg_rd(reg_rd),
		.reg_addr(reg_addr),
		.reg_din(reg_din),
		.qa_if(qa_if.pio),
		.qp_if(qp_if.pio),
		.wq_if(wq_if.pio),
		.sp_if(sp_if.pio),
		.pio_ack(pio_ack),
		.pio_rvalid(pio_rvalid),
		.pio_rdata(pio_rdata)
	);

	tm_cfg_mem #(
		.entry_t(queue_assoc_t)
	) queue_assoc_mem_i (
		.clk(clk),
		.rst_n(rst_n),
		.bus(qa_if.mem)
	);

	tm_cfg_mem #(
		.entry_t(queue_profile_t)
	) queue_profile_mem_i (
		.clk(clk),
		.rst_n(rst_n),
		.bus(qp_if.mem)
	);

	tm_cfg_mem #(
		.entry_t(wdrr_quantum_t)
	) wdrr_quantum_mem_i (
		.clk(clk),
		.rst_n(rst_n),
		.bus(wq_if.mem)
	);

	tm_cfg_mem #(
		.entry_t(shaping_profile_t)
	) shaping_cir_mem_i (
		.clk(clk),
		.rst_n(rst_n),
		.bus(sp_if.mem)
	);

endmodule

//--- design/tm_pio.sv
// ##############################
// PIO decoder for the TM config tables.
// Host holds reg_bs until pio_ack and waits for pio_ack low before the next access.
// Outputs only move on cycles with clk_div high.
// ##############################

`timescale 1ns/1ps

module tm_pio (
	input logic clk,
	input logic rst_n,
	input logic clk_div,

	input logic reg_bs,
	input logic reg_wr,
	input logic reg_rd,
	input tm_pio_pkg::pio_word_t reg_addr,
	input tm_pio_pkg::pio_word_t reg_din,

	tm_mem_if.pio qa_if,
	tm_mem_if.pio qp_if,
	tm_mem_if.pio wq_if,
	tm_mem_if.pio sp_if,

	output logic pio_ack,
	output logic pio_rvalid,
	output tm_pio_pkg::pio_word_t pio_rdata
);

	import tm_pio_pkg::*;

	tm_code_t code;
	logic [TM_ENTRY_AW-1:0] index;
	logic [3:0] hit;
	logic no_hit;
	logic none_ack;
	logic n_ack;
	logic sel_ack;
	pio_word_t n_rdata;

	assign code = reg_addr[TM_CODE_LSB +: TM_CODE_W];
	assign index = reg_addr[TM_ENTRY_AW-1:0];

	assign hit[0] = (code == TM_QUEUE_ASSOCIATION);
	assign hit[1] = (code == TM_QUEUE_PROFILE);
	assign hit[2] = (code == TM_WDRR_QUANTUM);
	assign hit[3] = (code == TM_SHAPING_PROFILE_CIR);
	assign no_hit = ~|hit;

	// Only sel is steered, the rest is broadcast to every table.
	assign qa_if.sel = reg_bs & hit[0];
	assign qp_if.sel = reg_bs & hit[1];
	assign wq_if.sel = reg_bs & hit[2];
	assign sp_if.sel = reg_bs & hit[3];

	assign qa_if.wr = reg_wr;
	assign qp_if.wr = reg_wr;
	assign wq_if.wr = reg_wr;
	assign sp_if.wr = reg_wr;

	assign qa_if.rd = reg_rd;
	assign qp_if.rd = reg_rd;
	assign wq_if.rd = reg_rd;
	assign sp_if.rd = reg_rd;

	assign qa_if.index = index;
	assign qp_if.index = index;
	assign wq_if.index = index;
	assign sp_if.index = index;

	assign qa_if.wdata = reg_din;
	assign qp_if.wdata = reg_din;
	assign wq_if.wdata = reg_din;
	assign sp_if.wdata = reg_din;

	always_comb begin
		sel_ack = none_ack;
		n_rdata = '0;  // Unmapped codes read as zero.
		case (code)
			TM_QUEUE_ASSOCIATION: begin
				sel_ack = qa_if.ack;
				n_rdata = qa_if.rdata;
			end
			TM_QUEUE_PROFILE: begin
				sel_ack = qp_if.ack;
				n_rdata = qp_if.rdata;
			end
			TM_WDRR_QUANTUM: begin
				sel_ack = wq_if.ack;
				n_rdata = wq_if.rdata;
			end
			TM_SHAPING_PROFILE_CIR: begin
				sel_ack = sp_if.ack;
				n_rdata = sp_if.rdata;
			end
			default: begin
				sel_ack = none_ack;
				n_rdata = '0;
			end
		endcase
	end

	// A table ack lingers one clock after reg_bs drops, so gate it here.
	assign n_ack = reg_bs & sel_ack;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			none_ack <= 1'b0;
			pio_ack <= 1'b0;
			pio_rvalid <= 1'b0;
			pio_rdata <= '0;
		end else begin
			if (reg_bs && no_hit && (reg_wr || reg_rd)) begin
				none_ack <= 1'b1;  // Nobody answers, so acknowledge locally.
			end else if (clk_div) begin
				none_ack <= 1'b0;
			end
			if (clk_div) begin
				pio_ack <= n_ack;
				pio_rvalid <= n_ack & reg_rd;
				pio_rdata <= (n_ack && reg_rd) ? n_rdata : '0;
			end
		end
	end

endmodule

//--- design/tm_cfg_mem.sv
// ##############################
// One TM config table of 16 entries.
// entry_t must not be wider than a PIO word.
// Writes keep the low payload bits, reads are zero-extended.
// ##############################

`timescale 1ns/1ps

module tm_cfg_mem #(
	parameter type entry_t = tm_pio_pkg::pio_word_t
) (
	input logic clk,
	input logic rst_n,
	tm_mem_if.mem bus
);

	import tm_pio_pkg::*;

	localparam int EW = $bits(entry_t);

	entry_t mem [TM_ENTRIES];
	logic first;
	pio_word_t rd_word;

	// First cycle of an access. Later cycles of a stalled host do nothing.
	assign first = bus.sel & ~bus.ack;

	always_comb begin
		rd_word = '0;
		rd_word[EW-1:0] = mem[bus.index];
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			bus.ack <= 1'b0;
			for (int i = 0; i < TM_ENTRIES; i++) begin
				mem[i] <= '0;
			end
		end else begin
			bus.ack <= bus.sel;  // Drops one clock after sel.
			if (first && bus.wr) begin
				mem[bus.index] <= entry_t'(bus.wdata[EW-1:0]);
			end
		end
	end

	// Captured together with the rise of ack and held while it stays high.
	always_ff @(posedge clk) begin
		if (first && bus.rd) begin
			bus.rdata <= rd_word;
		end
	end

endmodule

//--- design/tm_mem_if.sv
// ##############################
// Link from the PIO decoder to one config table.
// sel is held until the access ends, ack follows it by one clock.
// ##############################

`timescale 1ns/1ps

interface tm_mem_if;

	import tm_pio_pkg::*;

	logic sel;
	logic wr;
	logic rd;
	logic [TM_ENTRY_AW-1:0] index;
	pio_word_t wdata;
	logic ack;
	pio_word_t rdata;  // Valid while ack is high.

	modport pio (
		output sel, wr, rd, index, wdata,
		input ack, rdata
	);

	modport mem (
		input sel, wr, rd, index, wdata,
		output ack, rdata
	);

endinterface

//--- design/tm_pio_pkg.sv
// ##############################
// Bus widths, table codes and entry payloads of the TM config block.
// Every payload must fit in one PIO word.
// ##############################

package tm_pio_pkg;

	localparam int PIO_NBITS = 32;

	// Entry index sits in the low address bits, the table code right above it.
	localparam int TM_ENTRY_AW = 4;
	localparam int TM_ENTRIES = 1 << TM_ENTRY_AW;
	localparam int TM_CODE_W = 4;
	localparam int TM_CODE_LSB = TM_ENTRY_AW;

	typedef logic [PIO_NBITS-1:0] pio_word_t;
	typedef logic [TM_CODE_W-1:0] tm_code_t;

	localparam tm_code_t TM_QUEUE_ASSOCIATION = 4'd0;
	localparam tm_code_t TM_QUEUE_PROFILE = 4'd1;
	localparam tm_code_t TM_WDRR_QUANTUM = 4'd2;
	localparam tm_code_t TM_SHAPING_PROFILE_CIR = 4'd3;

	// Output port that a queue is attached to.
	typedef logic [7:0] queue_assoc_t;

	typedef struct packed {
		logic [11:0] depth_limit;  // Max queue depth in buffers.
		logic [11:0] drop_thresh;  // Tail drop starts above this fill level.
	} queue_profile_t;

	// Bytes credited per WDRR round.
	typedef logic [15:0] wdrr_quantum_t;

	typedef struct packed {
		logic [19:0] cir_rate;   // Token fill rate.
		logic [11:0] cir_burst;  // Bucket depth.
	} shaping_profile_t;

endpackage
